// File: lvds_rx_if.f
source/lvds_link_pkg.sv
source/adc_sample_pkg.sv
source/lvds_ddr_capture.sv
source/lvds_word_deser.sv
source/lvds_frame_align.sv
source/lvds_rx_if.sv
verification/lvds_rx_if_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the lvds receive testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module lvds_rx_if_tb -f lvds_rx_if.f --Mdir obj_dir -o lvds_rx_if_sim &&
  ./obj_dir/lvds_rx_if_sim | tee /dev/stderr | grep -q "Simulation passed" &&
  echo "run ok" ||
  { echo "run failed"; exit 1; }

// File: source/adc_sample_pkg.sv
// adc sample package: word-level types, multi-lane sample and frame pattern rule
`default_nettype none

package adc_sample_pkg;

  // widest word any lane can carry
  localparam int unsigned MAX_SAMPLE_BITS = 16;
  // most data lanes the sample struct holds
  localparam int unsigned MAX_LANES       = 4;

  // one converter word, right aligned, zeros above SAMPLE_BITS
  typedef logic [MAX_SAMPLE_BITS-1:0] sample_word_t;

  // one word per data lane, lane 0 first
  // unused lanes read as zero
  typedef struct packed {
    sample_word_t [0:MAX_LANES-1] lane;
  } adc_sample_t;

  // word alignment fsm
  typedef enum logic [1:0] {
    SEARCH,
    SETTLE,
    LOCKED
  } align_state_t;

  // frame lane pattern: upper half ones, lower half zeros, msb sent first
  function automatic sample_word_t frame_pattern(input int unsigned bits);
    sample_word_t pat;
    pat = '0;
    for (int i = bits / 2; i < bits; i++) begin
      pat[i] = 1'b1;
    end
    return pat;
  endfunction

endpackage

`default_nettype wire

// File: source/lvds_ddr_capture.sv
// lvds ddr capture: samples both edges of every lane and realigns them to the rising edge
`default_nettype none

module lvds_ddr_capture #(
  parameter int NUM_LANES = 3
) (
  input  wire logic                                     rx_clk,
  input  wire logic                                     rst,
  input  wire logic [NUM_LANES-1:0]                     pad_p,
  input  wire logic [NUM_LANES-1:0]                     pad_n,
  output      lvds_link_pkg::ddr_pair_t [NUM_LANES-1:0] pairs
);

  import lvds_link_pkg::*;

  // ************************************************************************
  // edge samplers
  // ************************************************************************

  // rising edge bit of the current cycle
  logic [NUM_LANES-1:0] rise_q;
  // falling edge bit, half a cycle later
  logic [NUM_LANES-1:0] fall_q;

  // differential input, p pin carries the bit
  always_ff @(posedge rx_clk) begin
    rise_q <= pad_p;
  end

  always_ff @(negedge rx_clk) begin
    fall_q <= pad_p;
  end

  // ************************************************************************
  // realign to rising edge
  // ************************************************************************

  // both halves move into the rx_clk rising domain together
  // bits seen at edge k appear here after edge k+1
  always_ff @(posedge rx_clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      pairs[i] <= ddr_pair_t'({rise_q[i], fall_q[i]});
    end
  end

  // n side must mirror p side on every lane once the link is up
  a_pad_diff : assert property (
    @(posedge rx_clk) disable iff (rst)
    pad_n == ~pad_p
  );

endmodule

`default_nettype wire

// File: source/lvds_frame_align.sv
// lvds frame aligner: word tick generator and frame-lane search and lock fsm
`default_nettype none

module lvds_frame_align #(
  parameter int SAMPLE_BITS = 8,
  parameter int LOCK_COUNT  = 4
) (
  input  wire logic                         rx_clk,
  input  wire logic                         rst,
  input  wire adc_sample_pkg::sample_word_t frame_word,
  input  wire logic                         frame_strobe,
  output      logic                         word_tick,
  output      lvds_link_pkg::bit_offset_t   bit_offset,
  output      logic                         aligned
);

  import lvds_link_pkg::*;
  import adc_sample_pkg::*;

  // one word every SAMPLE_BITS/2 cycles at two bits per cycle
  localparam int TICK_PERIOD = SAMPLE_BITS / 2;
  localparam int TICK_W      = (TICK_PERIOD > 1) ? $clog2(TICK_PERIOD) : 1;
  localparam int MATCH_W     = $clog2(LOCK_COUNT + 1);

  // expected word on the frame lane
  localparam sample_word_t FRAME_WORD = frame_pattern(SAMPLE_BITS);

  // ************************************************************************
  // word tick
  // ************************************************************************

  logic [TICK_W-1:0] tick_cnt;

  always_ff @(posedge rx_clk) begin
    if (rst) begin
      tick_cnt  <= '0;
      word_tick <= 1'b0;
    end else begin
      if (tick_cnt == TICK_W'(TICK_PERIOD - 1)) begin
        tick_cnt <= '0;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      // registered, first tick lands one period after reset
      word_tick <= (tick_cnt == TICK_W'(TICK_PERIOD - 1));
    end
  end

  // ************************************************************************
  // search and lock fsm
  // ************************************************************************

  align_state_t       state;
  logic [MATCH_W-1:0] match_cnt;
  logic               frame_match;

  assign frame_match = (frame_word == FRAME_WORD);

  // only acts on a fresh frame word
  always_ff @(posedge rx_clk) begin
    if (rst) begin
      state      <= SEARCH;
      match_cnt  <= '0;
      bit_offset <= '0;
      aligned    <= 1'b0;
    end else if (frame_strobe) begin
      case (state)
        SEARCH: begin
          if (!frame_match) begin
            // slide by one bit, wraps at the word width
            if (bit_offset == bit_offset_t'(SAMPLE_BITS - 1)) begin
              bit_offset <= '0;
            end else begin
              bit_offset <= bit_offset + 1'b1;
            end
            match_cnt <= '0;
            state     <= SETTLE;
          end else if (match_cnt == MATCH_W'(LOCK_COUNT - 1)) begin
            match_cnt <= '0;
            state     <= LOCKED;
            aligned   <= 1'b1;
          end else begin
            match_cnt <= match_cnt + 1'b1;
          end
        end
        SETTLE: begin
          // skip one word after an offset move
          state <= SEARCH;
        end
        LOCKED: begin
          // single bad frame word drops lock, count starts over
          if (!frame_match) begin
            aligned   <= 1'b0;
            match_cnt <= '0;
            state     <= SEARCH;
          end
        end
        default: begin
          state   <= SEARCH;
          aligned <= 1'b0;
        end
      endcase
    end
  end

  // aligned level tracks the fsm
  a_aligned_locked : assert property (
    @(posedge rx_clk) disable iff (rst)
    aligned |-> (state == LOCKED)
  );

endmodule

`default_nettype wire

// File: source/lvds_link_pkg.sv
// lvds link package: lane-level bit types shared by capture, deserializer and aligner
`default_nettype none

package lvds_link_pkg;

  // ************************************************************************
  // lane bits
  // ************************************************************************

  // bits delivered per lane per rx_clk cycle (one per edge)
  localparam int unsigned DDR_BITS = 2;

  // bit pair from one lane, one cycle
  // [1] rising edge bit, older in time
  // [0] falling edge bit, newest
  typedef logic [DDR_BITS-1:0] ddr_pair_t;

  // ************************************************************************
  // word boundary
  // ************************************************************************

  // bit offset of the word boundary, 0 .. SAMPLE_BITS-1
  // 4 bits covers words up to 16 bits
  typedef logic [3:0] bit_offset_t;

endpackage

`default_nettype wire

// File: source/lvds_rx_if.sv
// lvds receive interface top that ties ddr capture, per-lane deserializers and frame aligner together
`default_nettype none

module lvds_rx_if #(
  parameter int SAMPLE_BITS = 8,
  parameter int NUM_LANES   = 2,
  parameter int LOCK_COUNT  = 4
) (
  input  wire logic                        rx_clk,
  input  wire logic                        rst,
  input  wire logic [NUM_LANES-1:0]        lane_in_p,
  input  wire logic [NUM_LANES-1:0]        lane_in_n,
  input  wire logic                        frame_in_p,
  input  wire logic                        frame_in_n,
  output      adc_sample_pkg::adc_sample_t sample,
  output      logic                        sample_valid,
  output      logic                        aligned
);

  import lvds_link_pkg::*;
  import adc_sample_pkg::*;

  // data lanes plus the frame lane on top
  localparam int ALL_LANES = NUM_LANES + 1;
  localparam int FRAME_IDX = NUM_LANES;

  // ************************************************************************
  // internal signals
  // ************************************************************************

  ddr_pair_t [ALL_LANES-1:0] lane_pair;
  sample_word_t              lane_word [ALL_LANES];
  logic [ALL_LANES-1:0]      lane_strobe;
  logic                      word_tick;
  bit_offset_t               bit_offset;

  // capture with the frame lane as highest index
  lvds_ddr_capture #(
    .NUM_LANES (ALL_LANES)
  ) i_capture (
    .rx_clk (rx_clk),
    .rst    (rst),
    .pad_p  ({frame_in_p, lane_in_p}),
    .pad_n  ({frame_in_n, lane_in_n}),
    .pairs  (lane_pair)
  );

  // one deserializer per lane on a shared tick and offset
  for (genvar i = 0; i < ALL_LANES; i++) begin : g_lane
    lvds_word_deser #(
      .SAMPLE_BITS (SAMPLE_BITS)
    ) i_deser (
      .rx_clk      (rx_clk),
      .rst         (rst),
      .pair        (lane_pair[i]),
      .word_tick   (word_tick),
      .bit_offset  (bit_offset),
      .word        (lane_word[i]),
      .word_strobe (lane_strobe[i])
    );
  end

  // word boundary search on the frame lane
  lvds_frame_align #(
    .SAMPLE_BITS (SAMPLE_BITS),
    .LOCK_COUNT  (LOCK_COUNT)
  ) i_align (
    .rx_clk       (rx_clk),
    .rst          (rst),
    .frame_word   (lane_word[FRAME_IDX]),
    .frame_strobe (lane_strobe[FRAME_IDX]),
    .word_tick    (word_tick),
    .bit_offset   (bit_offset),
    .aligned      (aligned)
  );

  // ************************************************************************
  // output
  // ************************************************************************

  // data lanes into the sample with unused slots left at zero
  always_comb begin
    sample = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      sample.lane[i] = lane_word[i];
    end
  end

  // valid only once the frame lane is locked
  assign sample_valid = lane_strobe[FRAME_IDX] & aligned;

endmodule

`default_nettype wire

// File: source/lvds_word_deser.sv
// lvds word deserializer: shifts one lane's bit pairs and extracts a word at the bit offset
`default_nettype none

module lvds_word_deser #(
  parameter int SAMPLE_BITS = 8
) (
  input  wire logic                         rx_clk,
  input  wire logic                         rst,
  input  wire lvds_link_pkg::ddr_pair_t     pair,
  input  wire logic                         word_tick,
  input  wire lvds_link_pkg::bit_offset_t   bit_offset,
  output      adc_sample_pkg::sample_word_t word,
  output      logic                         word_strobe
);

  import lvds_link_pkg::*;
  import adc_sample_pkg::*;

  // window holds two words worth of bits, newest at bit 0
  localparam int WIN_BITS = 2 * SAMPLE_BITS;

  // ************************************************************************
  // shift window
  // ************************************************************************

  logic [WIN_BITS-1:0] shift_q;
  // window moved down by the offset, word sits in the low bits
  logic [WIN_BITS-1:0] window_sh;

  // two bits per cycle, rising edge bit ahead of the falling one
  always_ff @(posedge rx_clk) begin
    shift_q <= {shift_q[WIN_BITS-DDR_BITS-1:0], pair};
  end

  // drop the bit_offset newest bits
  assign window_sh = shift_q >> bit_offset;

  // ************************************************************************
  // word extract
  // ************************************************************************

  // word payload, loaded on tick only
  always_ff @(posedge rx_clk) begin
    if (word_tick) begin
      // oldest bit of the word lands on the msb
      word <= sample_word_t'(window_sh[SAMPLE_BITS-1:0]);
    end
  end

  // strobe trails the tick by one cycle, with the word
  always_ff @(posedge rx_clk) begin
    if (rst) begin
      word_strobe <= 1'b0;
    end else begin
      word_strobe <= word_tick;
    end
  end

  // offset from the aligner has to stay inside one word
  a_offset_range : assert property (
    @(posedge rx_clk) disable iff (rst)
    word_tick |-> (int'(bit_offset) < SAMPLE_BITS)
  );

endmodule

`default_nettype wire

// File: verification/lvds_rx_if_tb.sv
// lvds receive testbench: serial transmitter model, random data, reference queues and checks
`default_nettype none

module lvds_rx_if_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import adc_sample_pkg::*;

  localparam int SAMPLE_BITS = 8;
  localparam int NUM_LANES   = 2;
  localparam int LOCK_COUNT  = 4;

  // ************************************************************************
  // test constants
  // ************************************************************************

  localparam int RESET_CYCLES = 4;
  // two bits per rx_clk cycle
  localparam int WORD_CYCLES  = SAMPLE_BITS / 2;
  localparam int N_DATA       = 300;
  localparam int LOCK_BOUND   = SAMPLE_BITS * (LOCK_COUNT + 2) * WORD_CYCLES + 10;
  // two word periods plus the capture stages
  localparam int DROP_BOUND   = 2 * WORD_CYCLES + 2;
  localparam int TOTAL_WORDS  = 2 * (N_DATA + SAMPLE_BITS * (LOCK_COUNT + 2) + 10);
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * WORD_CYCLES + 200;

  localparam sample_word_t WORD_MASK  = sample_word_t'((1 << SAMPLE_BITS) - 1);
  // upper half ones, lower half zeros
  localparam sample_word_t FRAME_WORD = WORD_MASK & ~(WORD_MASK >> (SAMPLE_BITS / 2));
  localparam sample_word_t TRAIN_WORD = sample_word_t'(8'h5a);

  logic                 rx_clk = 1'b0;
  logic                 rst;
  logic [NUM_LANES-1:0] lane_in_p;
  logic [NUM_LANES-1:0] lane_in_n;
  logic                 frame_in_p;
  logic                 frame_in_n;
  adc_sample_t          sample;
  logic                 sample_valid;
  logic                 aligned;

  integer       seed;
  int           cyc = 0;
  bit           next_rise;
  bit           check_en;
  bit           skip_train;
  bit           first_rand;
  bit           lock_wait;
  bit           drop_wait;
  int           lock_start;
  int           drop_start;
  int           checked;
  adc_sample_t  train_sample;
  // expected words per data lane, oldest first
  sample_word_t exp_q [NUM_LANES][$];

  lvds_rx_if #(
    .SAMPLE_BITS (SAMPLE_BITS),
    .NUM_LANES   (NUM_LANES),
    .LOCK_COUNT  (LOCK_COUNT)
  ) i_lvds_rx_if (
    .rx_clk       (rx_clk),
    .rst          (rst),
    .lane_in_p    (lane_in_p),
    .lane_in_n    (lane_in_n),
    .frame_in_p   (frame_in_p),
    .frame_in_n   (frame_in_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .aligned      (aligned)
  );

  always #5 rx_clk = ~rx_clk;

  always @(posedge rx_clk) begin
    cyc <= cyc + 1;
  end

  // ************************************************************************
  // helpers
  // ************************************************************************

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_sample(input adc_sample_t got, input adc_sample_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED sample: got %h expected %h", got, exp));
    end
  endtask

  function automatic int random_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // transmitter, low nbits of each word msb first, one bit per clock edge
  task automatic send_word(input sample_word_t frame_w, input adc_sample_t data_w,
                           input int nbits);
    for (int b = nbits - 1; b >= 0; b--) begin
      if (next_rise) begin
        @(posedge rx_clk);
      end else begin
        @(negedge rx_clk);
      end
      #1;
      frame_in_p = frame_w[b];
      frame_in_n = ~frame_w[b];
      for (int l = 0; l < NUM_LANES; l++) begin
        lane_in_p[l] = data_w.lane[l][b];
        lane_in_n[l] = ~data_w.lane[l][b];
      end
      next_rise = !next_rise;
    end
  endtask

  // random data word on every lane, queued while the checker is armed
  task automatic send_random_word(input sample_word_t frame_w);
    adc_sample_t w;
    w = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      w.lane[l] = sample_word_t'($random(seed)) & WORD_MASK;
    end
    // first data word must stand out from the training word
    if (first_rand && w.lane[0] == TRAIN_WORD) begin
      w.lane[0] = w.lane[0] ^ sample_word_t'(1);
    end
    first_rand = 1'b0;
    if (check_en) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        exp_q[l].push_back(w.lane[l]);
      end
    end
    send_word(frame_w, w, SAMPLE_BITS);
  endtask

  // lead bits set the lane phase, then training words until lock
  task automatic wait_for_lock(input int lead_bits);
    lock_start = cyc;
    lock_wait  = 1'b1;
    send_word(FRAME_WORD, train_sample, lead_bits);
    while (lock_wait) begin
      send_word(FRAME_WORD, train_sample, SAMPLE_BITS);
    end
  endtask

  task automatic run_data_phase();
    for (int l = 0; l < NUM_LANES; l++) begin
      exp_q[l].delete();
    end
    checked    = 0;
    first_rand = 1'b1;
    skip_train = 1'b1;
    check_en   = 1'b1;
    while (checked < N_DATA) begin
      send_random_word(FRAME_WORD);
    end
    check_en = 1'b0;
  endtask

  // ************************************************************************
  // output monitor, sampled mid cycle
  // ************************************************************************

  task automatic watch_outputs();
    adc_sample_t exp;
    bit          have_prev;
    int          gap;
    have_prev = 1'b0;
    gap       = 0;
    forever begin
      @(negedge rx_clk);
      // quiet through reset and the first word after it
      if (cyc <= RESET_CYCLES + WORD_CYCLES) begin
        check_bit("aligned", aligned, 1'b0);
        check_bit("sample_valid", sample_valid, 1'b0);
      end
      if (lock_wait) begin
        if (aligned) begin
          lock_wait = 1'b0;
        end else if (cyc - lock_start > LOCK_BOUND) begin
          report_failure($sformatf("aligned did not rise within %0d cycles", LOCK_BOUND));
        end
      end
      if (drop_wait) begin
        if (!aligned) begin
          drop_wait = 1'b0;
        end else if (cyc - drop_start > DROP_BOUND) begin
          report_failure("aligned stayed high after a corrupted frame word");
        end
      end
      if (check_en && !aligned) begin
        report_failure("aligned dropped during the data phase");
      end
      // exactly one valid per word period while locked, none otherwise
      if (!aligned) begin
        check_bit("sample_valid", sample_valid, 1'b0);
        have_prev = 1'b0;
      end else if (have_prev) begin
        check_bit("sample_valid", sample_valid, gap == WORD_CYCLES);
      end
      gap = sample_valid ? 1 : gap + 1;
      if (sample_valid) begin
        have_prev = 1'b1;
      end
      // training words still in flight are skipped
      if (check_en && sample_valid && !(skip_train && sample.lane[0] == TRAIN_WORD)) begin
        skip_train = 1'b0;
        exp = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
          if (exp_q[l].size() == 0) begin
            report_failure($sformatf("valid sample but no word queued on lane %0d", l));
          end
          exp.lane[l] = exp_q[l].pop_front();
        end
        check_sample(sample, exp);
        checked = checked + 1;
      end
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge rx_clk);
    report_failure($sformatf("timeout, run not finished after %0d cycles", WATCHDOG_CYCLES));
  end

  // ************************************************************************
  // test sequence
  // ************************************************************************

  initial begin
    seed       = 32'h589e_f706;
    rst        = 1'b1;
    lane_in_p  = '0;
    lane_in_n  = '1;
    frame_in_p = 1'b0;
    frame_in_n = 1'b1;
    next_rise  = 1'b1;
    check_en   = 1'b0;
    skip_train = 1'b0;
    first_rand = 1'b0;
    lock_wait  = 1'b0;
    drop_wait  = 1'b0;
    lock_start = 0;
    drop_start = 0;
    checked    = 0;
    train_sample = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      train_sample.lane[l] = TRAIN_WORD;
    end
    fork
      watch_outputs();
    join_none
    repeat (RESET_CYCLES) @(posedge rx_clk);
    #1;
    rst = 1'b0;

    // lock from a random start phase, then random data
    wait_for_lock(random_below(SAMPLE_BITS));
    run_data_phase();

    // one inverted frame word drops the lock
    send_random_word(FRAME_WORD ^ WORD_MASK);
    drop_start = cyc;
    drop_wait  = 1'b1;
    while (drop_wait) begin
      send_random_word(FRAME_WORD);
    end

    // slip the lanes by a fresh nonzero bit count and relock
    wait_for_lock(1 + random_below(SAMPLE_BITS - 1));
    run_data_phase();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
